/* verif/exe_input_vectors.txt */
# name op src1 src2 dest reg_write flush | expected: result paddr product reg_write exc
# hex fields; result ignored for multiply and traps, product checked for multiply only
add_basic   ADD   00000005 00000003 01 1 0 00000008 00000000 0000000000000000 1 EXC_NONE
addu_wrap   ADDU  7fffffff 00000001 02 1 0 80000000 00000000 0000000000000000 1 EXC_NONE
add_ovf     ADD   7fffffff 00000001 03 1 0 80000000 00000000 0000000000000000 1 EXC_OVERFLOW
sub_ovf     SUB   80000000 00000001 04 1 0 7fffffff 00000000 0000000000000000 1 EXC_OVERFLOW
subu_basic  SUBU  00000003 00000005 05 1 0 fffffffe 00000000 0000000000000000 1 EXC_NONE
and_op      AND   f0f0f0f0 ff00ff00 06 1 0 f000f000 00000000 0000000000000000 1 EXC_NONE
xor_op      XOR   aaaaaaaa ffff0000 07 1 0 5555aaaa 00000000 0000000000000000 1 EXC_NONE
nor_op      NOR   0000ffff 00ff0000 08 1 0 ff000000 00000000 0000000000000000 1 EXC_NONE
lui_op      LUI   00000000 00001234 09 1 0 12340000 00000000 0000000000000000 1 EXC_NONE
slt_neg     SLT   ffffffff 00000001 0a 1 0 00000001 00000000 0000000000000000 1 EXC_NONE
sltu_big    SLTU  ffffffff 00000001 0b 1 0 00000000 00000000 0000000000000000 1 EXC_NONE
sll_op      SLL   00000004 0000000f 0c 1 0 000000f0 00000000 0000000000000000 1 EXC_NONE
srl_op      SRL   00000008 80000000 0d 1 0 00800000 00000000 0000000000000000 1 EXC_NONE
sra_op      SRA   00000008 80000000 0e 1 0 ff800000 00000000 0000000000000000 1 EXC_NONE
clo_top     CLO   ff000000 00000000 0f 1 0 00000008 00000000 0000000000000000 1 EXC_NONE
clo_ones    CLO   ffffffff 00000000 10 1 0 00000020 00000000 0000000000000000 1 EXC_NONE
clz_mid     CLZ   00010000 00000000 11 1 0 0000000f 00000000 0000000000000000 1 EXC_NONE
clz_zero    CLZ   00000000 00000000 12 1 0 00000020 00000000 0000000000000000 1 EXC_NONE
movz_take   MOVZ  12345678 00000000 13 1 0 12345678 00000000 0000000000000000 1 EXC_NONE
movn_skip   MOVN  12345678 00000000 14 1 0 12345678 00000000 0000000000000000 0 EXC_NONE
mult_neg    MULT  fffffffe 00000003 15 0 0 00000000 00000000 fffffffffffffffa 0 EXC_NONE
multu_big   MULTU fffffffe 00000003 16 0 0 00000000 00000000 00000002fffffffa 0 EXC_NONE
teq_hit     TEQ   00000007 00000007 00 0 0 00000000 00000000 0000000000000000 0 EXC_TRAP
tne_miss    TNE   00000007 00000007 00 0 0 00000000 00000000 0000000000000000 0 EXC_NONE
tlt_hit     TLT   ffffffff 00000000 00 0 0 00000000 00000000 0000000000000000 0 EXC_TRAP
tltu_miss   TLTU  ffffffff 00000000 00 0 0 00000000 00000000 0000000000000000 0 EXC_NONE
tge_hit     TGE   00000000 ffffffff 00 0 0 00000000 00000000 0000000000000000 0 EXC_TRAP
tgeu_miss   TGEU  00000000 ffffffff 00 0 0 00000000 00000000 0000000000000000 0 EXC_NONE
lw_kseg0    LW    80001000 00000010 17 1 0 80001010 00001010 0000000000000000 1 EXC_NONE
sw_kseg1    SW    bfc00000 00000004 00 0 0 bfc00004 1fc00004 0000000000000000 0 EXC_NONE
lw_mapped   LW    c0000000 00000020 18 1 0 c0000020 c0000020 0000000000000000 1 EXC_NONE
flush_add   ADD   00000001 00000001 19 1 1 00000002 00000000 0000000000000000 1 EXC_NONE
flush_mult  MULT  00000003 00000005 1a 0 1 00000000 00000000 000000000000000f 0 EXC_NONE
after_flush ADDU  00000001 00000002 1b 1 0 00000003 00000000 0000000000000000 1 EXC_NONE

/* verilog.f */
design/exe_pkg.sv
design/exe_alu.sv
design/exe_multiplier.sv
design/exe_result_unit.sv
design/exe_stage.sv
verif/exe_tb.sv

/* Bender.yml */
package:
  name: exe_stage
  description: "Execute stage of a five-stage MIPS-style integer pipeline"

sources:
  - files:
      - design/exe_pkg.sv
      - design/exe_alu.sv
      - design/exe_multiplier.sv
      - design/exe_result_unit.sv
      - design/exe_stage.sv
  - target: test
    files:
      - verif/exe_tb.sv

/* verif/exe_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_tb
    import exe_pkg::*;
();

    localparam int mul_latency    = 3;
    localparam int timeout_cycles = 50;

    logic      clk;
    logic      reset;
    logic      flush;
    logic      id_valid;
    exe_req_t  id_req;
    logic      mem_allowin;
    logic      allowin;
    logic      valid;
    exe_resp_t resp;

    // expected responses in issue order
    exe_resp_t exp_q[$];
    string     name_q[$];
    exe_op_e   op_q[$];
    int        due_q[$];

    exe_resp_t held_resp;
    logic      head_seen = 1'b0;
    logic      aborted = 1'b0;
    int        cycle_cnt = 0;
    int        stall_left = 0;
    int        sent_count = 0;
    int        resp_count = 0;
    int        value_errors = 0;
    int        protocol_errors = 0;
    int        timeout_errors = 0;
    int        file_errors = 0;

    exe_stage #(
        .mul_latency (mul_latency)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush),
        .id_valid_i    (id_valid),
        .id_req_i      (id_req),
        .mem_allowin_i (mem_allowin),
        .allowin_o     (allowin),
        .valid_o       (valid),
        .resp_o        (resp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // random stall of 0..3 cycles, then one open cycle
    always @(posedge clk) begin
        #2;
        if (stall_left != 0) begin
            mem_allowin = 1'b0;
            stall_left  = stall_left - 1;
        end else begin
            mem_allowin = 1'b1;
            stall_left  = $urandom % 4;
        end
    end

    function automatic exe_op_e op_from_name(input string text);
        exe_op_e op;
        op = op.first();
        for (int i = 0; i < op.num(); i++) begin
            if (op.name() == text) begin
                return op;
            end
            op = op.next();
        end
        $display("unknown opcode %s in the vector file", text);
        file_errors++;
        return op.first();
    endfunction

    function automatic exc_code_e exc_from_name(input string text);
        exc_code_e exc;
        exc = exc.first();
        for (int i = 0; i < exc.num(); i++) begin
            if (exc.name() == text) begin
                return exc;
            end
            exc = exc.next();
        end
        $display("unknown exception code %s in the vector file", text);
        file_errors++;
        return exc.first();
    endfunction

    // multiply and trap results carry no defined value
    function automatic logic result_defined(input exe_op_e op);
        case (op)
            MULT, MULTU, TEQ, TNE, TLT, TLTU, TGE, TGEU: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    function automatic int latency_of(input exe_op_e op);
        if (op == MULT || op == MULTU) begin
            return mul_latency;
        end
        return 1;
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("ERR %s %s expected %h actual %h", test, field, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_response(input string test, input exe_op_e op,
                                  input exe_resp_t expected, input exe_resp_t actual);
        if (result_defined(op)) begin
            check_field(test, "result", 64'(expected.result), 64'(actual.result));
        end
        check_field(test, "paddr", 64'(expected.paddr), 64'(actual.paddr));
        if (op == MULT || op == MULTU) begin
            check_field(test, "product", expected.product, actual.product);
        end
        check_field(test, "dest", 64'(expected.dest), 64'(actual.dest));
        check_field(test, "reg_write", 64'(expected.reg_write), 64'(actual.reg_write));
        check_field(test, "exc", 64'(expected.exc), 64'(actual.exc));
        check_field(test, "pc", 64'(expected.pc), 64'(actual.pc));
    endtask

    // sampled at the falling edge, a transfer completes on the next rising edge
    always @(negedge clk) begin
        if (!reset && valid) begin
            assert (exp_q.size() != 0) else begin
                $display("valid_o is high with no instruction outstanding, pc %h", resp.pc);
                protocol_errors++;
            end
            if (exp_q.size() != 0) begin
                if (!head_seen) begin
                    assert (cycle_cnt == due_q[0]) else begin
                        $display("ERR %s latency expected %0d actual %0d", name_q[0],
                                 due_q[0], cycle_cnt);
                        value_errors++;
                    end
                    check_response(name_q[0], op_q[0], exp_q[0], resp);
                    held_resp = resp;
                    head_seen = 1'b1;
                end else begin
                    assert (resp == held_resp) else begin
                        $display("ERR %s held response expected %h actual %h", name_q[0],
                                 held_resp, resp);
                        value_errors++;
                    end
                end
                if (mem_allowin) begin
                    exp_q.delete(0);
                    name_q.delete(0);
                    op_q.delete(0);
                    due_q.delete(0);
                    head_seen = 1'b0;
                    resp_count++;
                end else begin
                    assert (!allowin) else begin
                        $display("allowin_o is high while the response is stalled");
                        protocol_errors++;
                    end
                end
            end
        end
    end

    task automatic send_vector(input string test, input exe_req_t req, input logic do_flush,
                               input exe_resp_t expected);
        int   waited;
        logic taken;
        id_valid = 1'b1;
        id_req   = req;
        taken    = 1'b0;
        waited   = 0;
        while (!taken && waited < timeout_cycles) begin
            @(negedge clk);
            taken = allowin;
            waited++;
        end
        if (!taken) begin
            $display("timeout: %s was not accepted within %0d cycles", test, timeout_cycles);
            timeout_errors++;
            aborted = 1'b1;
        end else begin
            if (!do_flush) begin
                exp_q.push_back(expected);
                name_q.push_back(test);
                op_q.push_back(req.op);
                due_q.push_back(cycle_cnt + latency_of(req.op));
                sent_count++;
            end
            @(posedge clk);
            #2;
            // flush hits the instruction just taken
            if (do_flush) begin
                id_valid = 1'b0;
                flush    = 1'b1;
                @(posedge clk);
                #2;
                flush = 1'b0;
            end
        end
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d responses never left the stage", exp_q.size());
            timeout_errors++;
        end
        // idle window, catches a duplicated response
        repeat (4) @(negedge clk);
    endtask

    initial begin
        string              test;
        string              op_name;
        string              exc_name;
        logic [8*128-1:0]   skip_line;
        int                 fd;
        int                 code;
        int                 index;
        logic               done;
        logic [31:0]        src1;
        logic [31:0]        src2;
        logic [31:0]        exp_result;
        logic [31:0]        exp_paddr;
        logic [63:0]        exp_product;
        logic [4:0]         dest;
        logic               we;
        logic               do_flush;
        logic               exp_we;
        exe_req_t           req;
        exe_resp_t          expected;

        clk         = 1'b0;
        reset       = 1'b1;
        flush       = 1'b0;
        id_valid    = 1'b0;
        id_req      = '0;
        mem_allowin = 1'b1;
        // seeds the generator and draws the first stall length
        stall_left  = $urandom(72295) % 4;

        fd = $fopen("verif/exe_input_vectors.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open the vector file");
            file_errors++;
        end
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        done  = (fd == 0);
        index = 0;
        while (!done && !aborted) begin
            code = $fscanf(fd, "%s", test);
            if (code != 1) begin
                done = 1'b1;
            end else if (test[0] == "#") begin
                code = $fgets(skip_line, fd);
            end else begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %s", op_name, src1, src2,
                               dest, we, do_flush, exp_result, exp_paddr, exp_product,
                               exp_we, exc_name);
                if (code != 11) begin
                    $display("malformed vector line for %s", test);
                    file_errors++;
                    done = 1'b1;
                end else begin
                    req.op             = op_from_name(op_name);
                    req.src1           = src1;
                    req.src2           = src2;
                    req.dest           = dest;
                    req.reg_write      = we;
                    req.pc             = 32'h0040_0000 + 32'(index) * 4;
                    expected.result    = exp_result;
                    expected.paddr     = exp_paddr;
                    expected.product   = exp_product;
                    expected.dest      = dest;
                    expected.reg_write = exp_we;
                    expected.exc       = exc_from_name(exc_name);
                    expected.pc        = req.pc;
                    send_vector(test, req, do_flush, expected);
                    index++;
                end
            end
        end
        id_valid = 1'b0;
        drain_responses();
        if (fd != 0) begin
            $fclose(fd);
        end

        assert (resp_count == sent_count) else begin
            $display("%0d responses seen for %0d instructions sent", resp_count, sent_count);
            protocol_errors++;
        end
        $display("errors: value %0d protocol %0d timeout %0d file %0d",
                 value_errors, protocol_errors, timeout_errors, file_errors);
        if (value_errors + protocol_errors + timeout_errors + file_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/exe_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_stage import exe_pkg::*; #(
    parameter int mul_latency = 3
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush_i,
    input  logic      id_valid_i,
    input  exe_req_t  id_req_i,
    input  logic      mem_allowin_i,
    output logic      allowin_o,
    output logic      valid_o,
    output exe_resp_t resp_o
);

    logic        stage_valid;
    exe_req_t    req_q;
    logic        accept;
    logic        id_is_mul;
    logic        is_mul_q;
    logic        ready_go;
    logic        mul_start;
    logic        mul_done;
    word_t       alu_result;
    logic        alu_overflow;
    logic        alu_trap;
    logic [63:0] mul_product;

    assign accept    = id_valid_i && allowin_o;
    assign id_is_mul = (id_req_i.op == MULT) || (id_req_i.op == MULTU);
    assign is_mul_q  = (req_q.op == MULT) || (req_q.op == MULTU);

    // multiply holds the stage until the product is out
    assign ready_go  = is_mul_q ? mul_done : 1'b1;
    assign allowin_o = !stage_valid || (ready_go && mem_allowin_i);
    // a flushed occupant never leaves
    assign valid_o   = stage_valid && ready_go && !flush_i;
    assign mul_start = accept && id_is_mul;

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            stage_valid <= 1'b0;
        end else if (allowin_o) begin
            stage_valid <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            req_q <= '0;
        end else if (accept) begin
            req_q <= id_req_i;
        end
    end

    exe_alu u_alu (
        .op_i       (req_q.op),
        .src1_i     (req_q.src1),
        .src2_i     (req_q.src2),
        .result_o   (alu_result),
        .overflow_o (alu_overflow),
        .trap_o     (alu_trap)
    );

    exe_multiplier #(
        .mul_latency (mul_latency)
    ) u_multiplier (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .start_i     (mul_start),
        .is_signed_i (req_q.op == MULT),
        .src1_i      (req_q.src1),
        .src2_i      (req_q.src2),
        .product_o   (mul_product),
        .mul_done_o  (mul_done)
    );

    exe_result_unit u_result_unit (
        .req_i        (req_q),
        .alu_result_i (alu_result),
        .overflow_i   (alu_overflow),
        .trap_i       (alu_trap),
        .product_i    (mul_product),
        .resp_o       (resp_o)
    );

endmodule

`default_nettype wire

/* design/exe_result_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_result_unit import exe_pkg::*; (
    input  exe_req_t    req_i,
    input  word_t       alu_result_i,
    input  logic        overflow_i,
    input  logic        trap_i,
    input  logic [63:0] product_i,
    output exe_resp_t   resp_o
);

    logic       is_count;
    logic       is_move;
    logic       is_mem;
    logic       is_mul;
    logic       move_cond;
    logic       in_kseg;
    word_t      count_src;
    logic [5:0] lead_count;
    logic [3:0] top_nibble;

    assign is_count = (req_i.op == CLO) || (req_i.op == CLZ);
    assign is_move  = (req_i.op == MOVZ) || (req_i.op == MOVN);
    assign is_mem   = (req_i.op == LW) || (req_i.op == SW);
    assign is_mul   = (req_i.op == MULT) || (req_i.op == MULTU);

    // CLO counts zeros of the inverted word
    assign count_src = (req_i.op == CLO) ? ~req_i.src1 : req_i.src1;

    always_comb begin
        lead_count = 6'd32;
        // highest set bit is the last one seen
        for (int i = 0; i < 32; i++) begin
            if (count_src[i]) begin
                lead_count = 6'(31 - i);
            end
        end
    end

    assign move_cond = (req_i.op == MOVZ) ? (req_i.src2 == '0) : (req_i.src2 != '0);

    // kseg0 is 8..9, kseg1 is A..B
    assign top_nibble = alu_result_i[31:28];
    assign in_kseg    = (top_nibble[3:1] == KSEG0_NIBBLE[3:1]) ||
                        (top_nibble[3:1] == KSEG1_NIBBLE[3:1]);

    always_comb begin
        if (is_count) begin
            resp_o.result = {26'b0, lead_count};
        end else if (is_move) begin
            resp_o.result = req_i.src1;
        end else begin
            resp_o.result = alu_result_i;
        end

        if (!is_mem) begin
            resp_o.paddr = '0;
        end else if (in_kseg) begin
            resp_o.paddr = {3'b000, alu_result_i[28:0]};
        end else begin
            // mapped space goes through untranslated
            resp_o.paddr = alu_result_i;
        end

        if (is_move) begin
            resp_o.reg_write = req_i.reg_write && move_cond;
        end else begin
            resp_o.reg_write = req_i.reg_write;
        end

        // trap takes priority
        if (trap_i) begin
            resp_o.exc = EXC_TRAP;
        end else if (overflow_i) begin
            resp_o.exc = EXC_OVERFLOW;
        end else begin
            resp_o.exc = EXC_NONE;
        end

        // multiplier chain keeps moving, only a multiply owns its output
        if (is_mul) begin
            resp_o.product = product_i;
        end else begin
            resp_o.product = '0;
        end
        resp_o.dest    = req_i.dest;
        resp_o.pc      = req_i.pc;
    end

endmodule

`default_nettype wire

/* design/exe_multiplier.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_multiplier import exe_pkg::*; #(
    parameter int mul_latency = 3
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush_i,
    input  logic        start_i,
    input  logic        is_signed_i,
    input  word_t       src1_i,
    input  word_t       src2_i,
    output logic [63:0] product_o,
    output logic        mul_done_o
);

    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] prod_pipe [mul_latency];
    logic [2:0]         count;

    // sign or zero extension picks MULT vs MULTU
    assign mul_a = {is_signed_i & src1_i[31], src1_i};
    assign mul_b = {is_signed_i & src2_i[31], src2_i};

    // stage register in front counts as the first step
    assign prod_pipe[0] = mul_a * mul_b;

    for (genvar g = 1; g < mul_latency; g++) begin : g_pipe
        always_ff @(posedge clk) begin
            prod_pipe[g] <= prod_pipe[g-1];
        end
    end

    assign product_o = prod_pipe[mul_latency-1][63:0];

    // cycles left until the chain output belongs to the occupant
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            count      <= 3'd0;
            mul_done_o <= 1'b0;
        end else if (start_i) begin
            count      <= 3'(mul_latency - 1);
            mul_done_o <= (mul_latency == 1);
        end else if (count != 3'd0) begin
            count      <= count - 3'd1;
            mul_done_o <= (count == 3'd1);
        end
    end

endmodule

`default_nettype wire

/* design/exe_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_alu import exe_pkg::*; (
    input  exe_op_e op_i,
    input  word_t   src1_i,
    input  word_t   src2_i,
    output word_t   result_o,
    output logic    overflow_o,
    output logic    trap_o
);

    logic       do_sub;
    word_t      addend;
    word_t      sum;
    logic       carry;
    logic       add_ovf;
    logic       less_s;
    logic       less_u;
    logic       equal;
    logic [4:0] shamt;

    // adder subtracts for sub, compares and traps
    always_comb begin
        case (op_i)
            SUB, SUBU, SLT, SLTU,
            TEQ, TNE, TLT, TLTU, TGE, TGEU: begin
                do_sub = 1'b1;
            end
            default: begin
                do_sub = 1'b0;
            end
        endcase
    end

    assign addend       = do_sub ? ~src2_i : src2_i;
    assign {carry, sum} = {1'b0, src1_i} + {1'b0, addend} + 33'(do_sub);

    // same-sign inputs with flipped result sign
    assign add_ovf = (src1_i[31] == addend[31]) && (sum[31] != src1_i[31]);
    assign less_s  = sum[31] ^ add_ovf;
    // no carry out means a borrow
    assign less_u  = ~carry;
    assign equal   = (src1_i == src2_i);
    assign shamt   = src1_i[4:0];

    // only the trapping add/sub report overflow
    assign overflow_o = add_ovf && ((op_i == ADD) || (op_i == SUB));

    always_comb begin
        case (op_i)
            TEQ:     trap_o = equal;
            TNE:     trap_o = !equal;
            TLT:     trap_o = less_s;
            TLTU:    trap_o = less_u;
            TGE:     trap_o = !less_s;
            TGEU:    trap_o = !less_u;
            default: trap_o = 1'b0;
        endcase
    end

    always_comb begin
        case (op_i)
            AND: begin
                result_o = src1_i & src2_i;
            end
            OR: begin
                result_o = src1_i | src2_i;
            end
            XOR: begin
                result_o = src1_i ^ src2_i;
            end
            NOR: begin
                result_o = ~(src1_i | src2_i);
            end
            LUI: begin
                result_o = {src2_i[15:0], 16'h0000};
            end
            SLT: begin
                result_o = {31'b0, less_s};
            end
            SLTU: begin
                result_o = {31'b0, less_u};
            end
            SLL: begin
                result_o = src2_i << shamt;
            end
            SRL: begin
                result_o = src2_i >> shamt;
            end
            SRA: begin
                result_o = $signed(src2_i) >>> shamt;
            end
            // add/sub family and load/store address
            default: begin
                result_o = sum;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // execute opcodes, decoded upstream
    typedef enum logic [4:0] {
        // arithmetic
        ADD, ADDU, SUB, SUBU,
        // logic
        AND, OR, XOR, NOR, LUI,
        // compare
        SLT, SLTU,
        // shifts
        SLL, SRL, SRA,
        // leading count
        CLO, CLZ,
        // conditional move
        MOVZ, MOVN,
        // multiply
        MULT, MULTU,
        // traps
        TEQ, TNE, TLT, TLTU, TGE, TGEU,
        // memory
        LW, SW
    } exe_op_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_OVERFLOW,
        EXC_TRAP
    } exc_code_e;

    // request from decode
    typedef struct packed {
        exe_op_e   op;
        word_t     src1;
        word_t     src2;
        reg_addr_t dest;
        logic      reg_write;
        word_t     pc;
    } exe_req_t;

    // response to memory stage
    typedef struct packed {
        word_t       result;
        word_t       paddr;
        logic [63:0] product;
        reg_addr_t   dest;
        logic        reg_write;
        exc_code_e   exc;
        word_t       pc;
    } exe_resp_t;

    // unmapped kernel segments, two nibble values each
    localparam logic [3:0] KSEG0_NIBBLE = 4'h8;
    localparam logic [3:0] KSEG1_NIBBLE = 4'hA;

endpackage

`default_nettype wire
